// File: include/rlbp_macros.svh
/* widths, channel count, bus base nibble and register map offsets
   for the readout timing generator */

`ifndef RLBP_MACROS_SVH
`define RLBP_MACROS_SVH

// timer and channel sizing
`define RLBP_TW          12     // edge, period and count width
`define RLBP_NCH         8      // timed waveform channels

// wishbone bus sizing
`define RLBP_DW          32
`define RLBP_AW          32

// address decode, compared against adr[31:28]
`define RLBP_BASE_NIBBLE 4'd3

// register map within the slave window, byte offsets on adr[7:0]
`define RLBP_CH_STRIDE   8      // rise at 8k, fall at 8k+4
`define RLBP_OFF_PERIOD  64
`define RLBP_OFF_CTRL    68     // bit 0 is run

`endif

// File: hdl/rlbp_pkg.sv
/* shared types for the timing generator: wishbone request and response,
   edge pairs, sequencer configuration and the output channel vector */

`include "rlbp_macros.svh"

package rlbp_pkg;

    // one count position within a frame
    typedef logic [`RLBP_TW-1:0] timer_t;

    // rise and fall positions of one channel
    typedef struct packed {
        timer_t rise;   // first count with the channel high
        timer_t fall;   // first count with the channel low again
    } edge_pair_t;

    // master to slave strobes and payload
    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        logic [`RLBP_DW/8-1:0]    sel;
        logic [`RLBP_AW-1:0]      adr;
        logic [`RLBP_DW-1:0]      dat;
    } wb_req_t;

    // slave to master, ack and read data
    typedef struct packed {
        logic                     ack;
        logic [`RLBP_DW-1:0]      dat;
    } wb_rsp_t;

    // everything the register bank hands to the sequencer
    typedef struct packed {
        edge_pair_t [`RLBP_NCH-1:0] edges;  // index k is channel k
        timer_t                     period; // last count of a frame
        logic                       run;
    } seq_cfg_t;

    // waveform outputs, channel 0 first
    typedef struct packed {
        logic vd1;
        logic vd2;
        logic sw1;
        logic sw2;
        logic sh;
        logic sh_cmp;
        logic sh_rst;
        logic counter_rst;
    } chan_vec_t;

endpackage

// File: hdl/rlbp_wb_regs.sv
/* wishbone slave with the edge, period and control registers,
   single-cycle registered ack and read data */

`timescale 1ns/1ps
`include "rlbp_macros.svh"

module rlbp_wb_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  rlbp_pkg::wb_req_t    wb_req_i,
    output rlbp_pkg::wb_rsp_t    wb_rsp_o,
    output rlbp_pkg::seq_cfg_t   cfg_o
);

    import rlbp_pkg::*;

    localparam int CH_W = $clog2(`RLBP_NCH);

    seq_cfg_t              cfg_q;
    logic                  ack_q;
    logic [`RLBP_DW-1:0]   rdat_q;

    logic                  valid;
    logic                  wr_en;
    logic [7:0]            off;
    logic [7:0]            lane;       // byte position inside one channel slot
    logic [CH_W-1:0]       ch_idx;
    logic                  in_edges;
    logic                  is_rise;
    logic                  is_fall;
    logic                  is_period;
    logic                  is_ctrl;
    logic [`RLBP_DW-1:0]   rd_data;

    // request decode
    assign valid = wb_req_i.cyc && wb_req_i.stb
                   && (wb_req_i.adr[`RLBP_AW-1:`RLBP_AW-4] == `RLBP_BASE_NIBBLE);
    assign wr_en = valid && wb_req_i.we && wb_req_i.sel[0];   // only byte lane 0 counts

    assign off      = wb_req_i.adr[7:0];
    assign lane     = 8'(off % `RLBP_CH_STRIDE);
    assign ch_idx   = CH_W'(off / `RLBP_CH_STRIDE);
    assign in_edges = off < `RLBP_NCH * `RLBP_CH_STRIDE;

    assign is_rise   = in_edges && (lane == 8'd0);
    assign is_fall   = in_edges && (lane == 8'(`RLBP_CH_STRIDE / 2));
    assign is_period = (off == 8'(`RLBP_OFF_PERIOD));
    assign is_ctrl   = (off == 8'(`RLBP_OFF_CTRL));

    // read mux, anything unmapped reads as zero
    always_comb begin
        rd_data = '0;
        if (is_rise) begin
            rd_data = `RLBP_DW'(cfg_q.edges[ch_idx].rise);
        end else if (is_fall) begin
            rd_data = `RLBP_DW'(cfg_q.edges[ch_idx].fall);
        end else if (is_period) begin
            rd_data = `RLBP_DW'(cfg_q.period);
        end else if (is_ctrl) begin
            rd_data[0] = cfg_q.run;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_q  <= '0;
            ack_q  <= 1'b0;
            rdat_q <= '0;
        end else begin
            ack_q <= valid;     // one ack per valid cycle, held stb acks every cycle
            if (valid) begin
                rdat_q <= rd_data;  // value before this cycle's write
            end

            if (wr_en) begin
                if (is_rise) begin
                    cfg_q.edges[ch_idx].rise <= wb_req_i.dat[`RLBP_TW-1:0];
                end else if (is_fall) begin
                    cfg_q.edges[ch_idx].fall <= wb_req_i.dat[`RLBP_TW-1:0];
                end else if (is_period) begin
                    cfg_q.period <= wb_req_i.dat[`RLBP_TW-1:0];
                end else if (is_ctrl) begin
                    cfg_q.run <= wb_req_i.dat[0];
                end
            end
        end
    end

    assign wb_rsp_o = wb_rsp_t'{ack: ack_q, dat: rdat_q};
    assign cfg_o    = cfg_q;

endmodule

// File: hdl/rlbp_frame_counter.sv
/* frame position counter, advances while run is set and wraps
   after the programmed period with a one-cycle done pulse */

`timescale 1ns/1ps

module rlbp_frame_counter (
    input  logic                 clk,
    input  logic                 rst,
    input  rlbp_pkg::seq_cfg_t   cfg_i,
    output rlbp_pkg::timer_t     count_o,
    output logic                 frame_done_o
);

    import rlbp_pkg::*;

    timer_t count_q;
    logic   done_q;
    logic   at_end;     // last slot of the frame
    logic   past_end;   // period moved below the count mid-frame

    assign at_end   = (count_q == cfg_i.period);
    assign past_end = (count_q > cfg_i.period);

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= cfg_i.run && at_end;

            if (!cfg_i.run) begin
                count_q <= '0;                  // parked at frame start
            end else if (at_end || past_end) begin
                // a shrunk period restarts the frame without a done pulse
                count_q <= '0;
            end else begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    assign count_o      = count_q;
    assign frame_done_o = done_q;

endmodule

// File: hdl/rlbp_pulse_gen.sv
/* per-channel window compare of the frame count against rise and fall,
   registered onto the named waveform outputs */

`timescale 1ns/1ps
`include "rlbp_macros.svh"

module rlbp_pulse_gen (
    input  logic                 clk,
    input  logic                 rst,
    input  rlbp_pkg::seq_cfg_t   cfg_i,
    input  rlbp_pkg::timer_t     count_i,
    output rlbp_pkg::chan_vec_t  chan_o
);

    import rlbp_pkg::*;

    logic [`RLBP_NCH-1:0] hit;
    chan_vec_t            chan_d;
    chan_vec_t            chan_q;

    // half-open window rise <= count < fall
    // rise >= fall gives an empty window, so the channel stays low
    for (genvar k = 0; k < `RLBP_NCH; k++) begin : g_win
        logic after_rise;
        logic before_fall;

        assign after_rise  = (count_i >= cfg_i.edges[k].rise);
        assign before_fall = (count_i <  cfg_i.edges[k].fall);
        assign hit[k]      = cfg_i.run && after_rise && before_fall;
    end

    // channel index to output name
    always_comb begin
        chan_d.vd1         = hit[0];
        chan_d.vd2         = hit[1];
        chan_d.sw1         = hit[2];
        chan_d.sw2         = hit[3];
        chan_d.sh          = hit[4];
        chan_d.sh_cmp      = hit[5];
        chan_d.sh_rst      = hit[6];
        chan_d.counter_rst = hit[7];
    end

    // one register stage, lines up with the frame done pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            chan_q <= '0;
        end else begin
            chan_q <= chan_d;
        end
    end

    assign chan_o = chan_q;

endmodule

// File: hdl/rlbp_top.sv
/* readout timing generator top, wishbone register bank feeding
   the frame counter and the waveform generator */

`timescale 1ns/1ps

module rlbp_top (
    input  logic                 clk,
    input  logic                 rst,
    input  rlbp_pkg::wb_req_t    wb_req_i,
    output rlbp_pkg::wb_rsp_t    wb_rsp_o,
    output rlbp_pkg::chan_vec_t  chan_o,
    output logic                 frame_done_o
);

    import rlbp_pkg::*;

    seq_cfg_t cfg;      // edges, period and run from the bus
    timer_t   count;    // current frame position

    // bus side
    rlbp_wb_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .wb_req_i (wb_req_i),
        .wb_rsp_o (wb_rsp_o),
        .cfg_o    (cfg)
    );

    // frame timing
    rlbp_frame_counter u_counter (
        .clk          (clk),
        .rst          (rst),
        .cfg_i        (cfg),
        .count_o      (count),
        .frame_done_o (frame_done_o)
    );

    // waveform outputs
    rlbp_pulse_gen u_pulses (
        .clk     (clk),
        .rst     (rst),
        .cfg_i   (cfg),
        .count_i (count),
        .chan_o  (chan_o)
    );

endmodule

// File: test/rlbp_assertions.sv
/* concurrent checks on the bus ack, run gating of the waveforms
   and the frame done pulse, bound into the top level */

`timescale 1ns/1ps
`include "rlbp_macros.svh"

module rlbp_assertions (
    input  logic                 clk,
    input  logic                 rst,
    input  rlbp_pkg::wb_req_t    wb_req_i,
    input  rlbp_pkg::wb_rsp_t    wb_rsp_i,
    input  rlbp_pkg::chan_vec_t  chan_i,
    input  logic                 frame_done_i,
    input  logic                 run_i
);

    import rlbp_pkg::*;

    logic req_valid;

    assign req_valid = wb_req_i.cyc && wb_req_i.stb
                       && (wb_req_i.adr[`RLBP_AW-1:`RLBP_AW-4] == `RLBP_BASE_NIBBLE);

    // every ack answers a request one cycle earlier
    a_ack_follows_request: assert property (
        @(posedge clk) disable iff (rst) wb_rsp_i.ack |-> $past(req_valid)
    ) else $error("ack without a valid request in the previous cycle");

    a_chan_gated: assert property (
        @(posedge clk) disable iff (rst) !run_i |=> (chan_i == '0)
    ) else $error("waveform output high one cycle after run was low");

    // done is registered, so the run bit of the previous cycle gates it
    a_done_needs_run: assert property (
        @(posedge clk) disable iff (rst) !$past(run_i) |-> !frame_done_i
    ) else $error("frame done pulse while run was low");

endmodule

bind rlbp_top rlbp_assertions u_assertions (
    .clk          (clk),
    .rst          (rst),
    .wb_req_i     (wb_req_i),
    .wb_rsp_i     (wb_rsp_o),
    .chan_i       (chan_o),
    .frame_done_i (frame_done_o),
    .run_i        (cfg.run)
);

// File: test/rlbp_tb.sv
/* testbench for the readout timing generator: bus tasks, lcg stimulus,
   reference window model, frame monitor, watchdog and summary */

`timescale 1ns/1ps
`include "rlbp_macros.svh"

module rlbp_tb;

    import rlbp_pkg::*;

    localparam int FRAMES      = 3;     // frames compared in the run test
    localparam int MIN_PERIOD  = 20;
    localparam int MAX_PERIOD  = 40;
    localparam int BUS_OPS     = 100;   // upper bound on bus transfers
    localparam int WATCHDOG_NS = (BUS_OPS * 4 + (FRAMES + 4) * (MAX_PERIOD + 1) + 200) * 20;

    logic      clk = 1'b0;
    logic      rst;
    wb_req_t   wb_req;
    wb_rsp_t   wb_rsp;
    chan_vec_t chan;
    logic      frame_done;

    logic [31:0] rng = 32'h97dd8a06;
    int          err_cnt = 0;
    int          check_cnt = 0;

    // programmed sequence, mirrored for the reference model
    int          rise_v [`RLBP_NCH];
    int          fall_v [`RLBP_NCH];
    int          period_v;

    // monitor state
    logic        mon_en = 1'b0;
    logic        frame_open;
    logic        empty_high = 1'b0;  // a channel with rise >= fall went high
    int          since_done;
    int          frames_seen;
    int          frame_checks = 0;
    int          edge_checks = 0;
    int          high_cnt [`RLBP_NCH];
    logic        edge_seen [`RLBP_NCH];
    logic        prev_lvl [`RLBP_NCH];

    rlbp_top dut0 (
        .clk          (clk),
        .rst          (rst),
        .wb_req_i     (wb_req),
        .wb_rsp_o     (wb_rsp),
        .chan_o       (chan),
        .frame_done_o (frame_done)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // high cycles of one channel over counts 0 to period
    function automatic int expected_high(input int rise, input int fall, input int period);
        int n;
        n = 0;
        for (int c = 0; c <= period; c++) begin
            if (c >= rise && c < fall) begin
                n++;
            end
        end
        return n;
    endfunction

    // low to high transition inside a frame, an always-high channel has none
    function automatic logic has_rising_edge(input int rise, input int fall, input int period);
        return (rise < fall) && (rise <= period) && !(rise == 0 && fall > period);
    endfunction

    function automatic logic channel_level(input chan_vec_t c, input int k);
        case (k)
            0:       return c.vd1;
            1:       return c.vd2;
            2:       return c.sw1;
            3:       return c.sw2;
            4:       return c.sh;
            5:       return c.sh_cmp;
            6:       return c.sh_rst;
            default: return c.counter_rst;
        endcase
    endfunction

    // register index 0..17 to byte offset
    function automatic logic [7:0] reg_offset(input int i);
        if (i < 2 * `RLBP_NCH) begin
            return 8'((i / 2) * `RLBP_CH_STRIDE + (i % 2) * (`RLBP_CH_STRIDE / 2));
        end else if (i == 2 * `RLBP_NCH) begin
            return 8'(`RLBP_OFF_PERIOD);
        end
        return 8'(`RLBP_OFF_CTRL);
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        check_cnt++;
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s, got %0h, expected %0h", $time, msg, actual, expected);
            err_cnt++;
        end
    endtask

    // one transfer, called and returning on a falling edge
    task automatic bus_cycle(input logic we, input logic [3:0] sel, input logic [7:0] off,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        int waited;
        waited = 0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.sel = sel;
        wb_req.adr = {`RLBP_BASE_NIBBLE, 20'h0, off};
        wb_req.dat = wdat;
        @(negedge clk);
        while (!wb_rsp.ack && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (!wb_rsp.ack) begin
            $display("bus transfer at offset %0h was never acknowledged", off);
            err_cnt++;
        end
        rdat   = wb_rsp.dat;
        wb_req = '0;                  // stb dropped after the ack
        @(negedge clk);
    endtask

    task automatic wb_write(input logic [7:0] off, input logic [31:0] wdat,
                            input logic [3:0] sel);
        logic [31:0] unused;
        bus_cycle(1'b1, sel, off, wdat, unused);
    endtask

    task automatic wb_read(input logic [7:0] off, output logic [31:0] rdat);
        bus_cycle(1'b0, 4'hf, off, 32'h0, rdat);
    endtask

    // frame monitor, chan_o counts c show up c+1 cycles after frame_done_o
    always @(negedge clk) begin : frame_monitor
        logic lvl;
        if (!mon_en) begin
            frame_open  = 1'b0;
            frames_seen = 0;
            since_done  = 0;
            for (int k = 0; k < `RLBP_NCH; k++) begin
                high_cnt[k]  = 0;
                edge_seen[k] = 1'b0;
                prev_lvl[k]  = 1'b0;
            end
        end else begin
            since_done++;
            for (int k = 0; k < `RLBP_NCH; k++) begin
                lvl = channel_level(chan, k);
                if (lvl) begin
                    high_cnt[k]++;
                    if (rise_v[k] >= fall_v[k]) empty_high = 1'b1;
                end
                if (lvl && !prev_lvl[k] && frame_open && !edge_seen[k]) begin
                    check_equal(since_done, rise_v[k] + 1, $sformatf("first rise of ch %0d", k));
                    edge_seen[k] = 1'b1;
                    edge_checks++;
                end
                prev_lvl[k] = lvl;
            end
            if (frame_done) begin
                if (frame_open) begin
                    for (int k = 0; k < `RLBP_NCH; k++) begin
                        check_equal(high_cnt[k], expected_high(rise_v[k], fall_v[k], period_v),
                                    $sformatf("high cycles of ch %0d", k));
                        if (has_rising_edge(rise_v[k], fall_v[k], period_v)) begin
                            check_equal(edge_seen[k], 1'b1, $sformatf("rise of ch %0d", k));
                        end
                    end
                    check_equal(since_done, period_v + 1, "frame_done spacing");
                    frames_seen++;
                    frame_checks++;
                end
                frame_open = 1'b1;
                since_done = 0;
                for (int k = 0; k < `RLBP_NCH; k++) begin
                    high_cnt[k]  = 0;
                    edge_seen[k] = 1'b0;
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("simulation hung, watchdog expired after %0d ns", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

    initial begin : main
        logic [31:0] rdat;
        logic [31:0] val;
        int          exp_reg [2 * `RLBP_NCH + 2];
        int          err_start;

        rst    = 1'b1;
        wb_req = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        // test 1, reset values
        err_start = err_cnt;
        for (int i = 0; i < 2 * `RLBP_NCH + 2; i++) begin
            wb_read(reg_offset(i), rdat);
            check_equal(rdat, 0, $sformatf("reset value at %0h", reg_offset(i)));
            check_equal(chan, 0, "chan_o after reset");
            check_equal(frame_done, 0, "frame_done_o after reset");
        end
        $display("test 1 reset values finished, %0d errors", err_cnt - err_start);

        // test 2, register access
        err_start = err_cnt;
        for (int i = 0; i < 2 * `RLBP_NCH + 2; i++) begin
            rng = lcg_step(rng);
            val = rng;
            exp_reg[i] = (i == 2 * `RLBP_NCH + 1) ? int'(val & 32'h1) : int'(val & 32'hfff);
            wb_write(reg_offset(i), val, 4'hf);
        end
        for (int i = 0; i < 2 * `RLBP_NCH + 2; i++) begin
            wb_read(reg_offset(i), rdat);
            check_equal(rdat, exp_reg[i], $sformatf("readback at %0h", reg_offset(i)));
        end
        wb_write(8'(`RLBP_OFF_PERIOD), 32'h0000_0abc, 4'b1110);  // byte lane 0 off
        wb_write(reg_offset(6), 32'h0000_0123, 4'b1110);
        wb_read(8'(`RLBP_OFF_PERIOD), rdat);
        check_equal(rdat, exp_reg[2 * `RLBP_NCH], "period after masked write");
        wb_read(reg_offset(6), rdat);
        check_equal(rdat, exp_reg[6], "rise of ch 3 after masked write");
        wb_read(8'h02, rdat);
        check_equal(rdat, 0, "unmapped offset 02");
        wb_read(8'h48, rdat);
        check_equal(rdat, 0, "unmapped offset 48");
        wb_read(8'hfc, rdat);
        check_equal(rdat, 0, "unmapped offset fc");
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.sel = 4'hf;
        wb_req.adr = {4'h5, 20'h0, 8'(`RLBP_OFF_PERIOD)};
        repeat (10) begin
            @(negedge clk);
            check_equal(wb_rsp.ack, 0, "ack at foreign base address");
        end
        wb_req = '0;
        @(negedge clk);
        wb_write(8'(`RLBP_OFF_CTRL), 32'h0, 4'hf);
        $display("test 2 register access finished, %0d errors", err_cnt - err_start);

        // test 3 and 4, random sequence over several frames
        err_start = err_cnt;
        rng = lcg_step(rng);
        period_v = MIN_PERIOD + int'((rng >> 8) % (MAX_PERIOD - MIN_PERIOD + 1));
        for (int k = 0; k < `RLBP_NCH; k++) begin
            rng = lcg_step(rng);
            if (k == `RLBP_NCH - 1) begin
                rise_v[k] = 5 + int'((rng >> 8) % period_v);
                rng = lcg_step(rng);
                fall_v[k] = int'((rng >> 8) % (rise_v[k] + 1));   // empty window
            end else begin
                rise_v[k] = int'((rng >> 8) % (period_v + 5));
                rng = lcg_step(rng);
                fall_v[k] = int'((rng >> 8) % (period_v + 5));
            end
            wb_write(reg_offset(2 * k), rise_v[k], 4'hf);
            wb_write(reg_offset(2 * k + 1), fall_v[k], 4'hf);
        end
        wb_write(8'(`RLBP_OFF_PERIOD), period_v, 4'hf);
        mon_en = 1'b1;
        wb_write(8'(`RLBP_OFF_CTRL), 32'h1, 4'hf);
        while (frames_seen < FRAMES) @(negedge clk);
        mon_en = 1'b0;
        $display("test 3 window counts finished, period %0d, %0d frames, %0d errors so far",
                 period_v, frame_checks, err_cnt - err_start);
        $display("test 4 edge timing finished, %0d first edges checked", edge_checks);

        // test 5, stop
        err_start = err_cnt;
        wb_write(8'(`RLBP_OFF_CTRL), 32'h0, 4'hf);
        repeat (2) @(negedge clk);
        check_equal(chan, 0, "chan_o after run cleared");
        repeat (2 * (period_v + 1)) begin
            @(negedge clk);
            check_equal(frame_done, 0, "frame_done_o while stopped");
            check_equal(chan, 0, "chan_o while stopped");
        end
        check_equal(empty_high, 0, "channel with rise >= fall went high");
        $display("test 5 stop finished, %0d errors", err_cnt - err_start);

        $display("checks %0d, errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: rlbp_top.f
+incdir+include
hdl/rlbp_pkg.sv
hdl/rlbp_wb_regs.sv
hdl/rlbp_frame_counter.sv
hdl/rlbp_pulse_gen.sv
hdl/rlbp_top.sv
test/rlbp_assertions.sv
test/rlbp_tb.sv

// File: Bender.yml
package:
  name: rlbp

export_include_dirs:
  - include

sources:
  - files:
      - hdl/rlbp_pkg.sv
      - hdl/rlbp_wb_regs.sv
      - hdl/rlbp_frame_counter.sv
      - hdl/rlbp_pulse_gen.sv
      - hdl/rlbp_top.sv
  - target: test
    files:
      - test/rlbp_assertions.sv
      - test/rlbp_tb.sv
